// ==== files.f ====
+incdir+sim
src/exu_pkg.sv
src/regfile_if.sv
src/csr_if.sv
src/regfile.sv
src/csr_file.sv
src/alu.sv
src/exu_ctrl.sv
src/exu_top.sv
sim/tb_exu.sv

// ==== Makefile ====
# Verilator simulation of the RV32I execute unit

.PHONY: run clean

run:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_exu \
		-Mdir obj_dir -f files.f
	@out="$$(./obj_dir/Vtb_exu)"; echo "$$out"; \
		echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// ==== sim/exu_ref_model.svh ====
// ----------------------------------------------------------
// reference model of the execute unit: register array,
// machine CSRs and the effect of each RV32I instruction
// ----------------------------------------------------------
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

logic [31:0] m_regs [0:31];
logic [31:0] m_mtvec;
logic [31:0] m_mepc;
logic [31:0] m_mcause;
logic [31:0] m_mstatus;

task automatic model_reset();
    for (int k = 0; k < 32; k++) begin
        m_regs[k] = '0;
    end
    m_mtvec   = 32'h8000_0000;
    m_mepc    = '0;
    m_mcause  = '0;
    m_mstatus = '0;
endtask

// integer result, alt selects sub or sra
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic [31:0] csr_read(input logic [11:0] addr);
    case (addr)
        12'h300: return m_mstatus;
        12'h305: return m_mtvec;
        12'h341: return m_mepc;
        12'h342: return m_mcause;
        12'hF11: return 32'h7973_7978;  // "ysyx"
        default: return 32'h0;          // marchid and unknown
    endcase
endfunction

task automatic csr_write(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
        12'h300: m_mstatus = val;
        12'h305: m_mtvec   = val;
        12'h341: m_mepc    = val;
        12'h342: m_mcause  = val;
        default: ;  // read-only ids
    endcase
endtask

// one instruction: updates the model state, returns next pc and taken flag
task automatic model_exec(input logic [31:0] w, input logic [31:0] pc,
                          output logic [31:0] npc, output logic taken);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic [31:0] old;
    logic        wr;
    logic        cond;
    a     = m_regs[w[19:15]];
    b     = m_regs[w[24:20]];
    imm   = {{20{w[31]}}, w[31:20]};
    npc   = pc + 32'd4;
    taken = 1'b0;
    wr    = 1'b1;
    res   = '0;
    cond  = 1'b0;
    case (w[6:0])
        op_reg:   res = alu_ref(w[14:12], w[30], a, b);
        op_imm:   res = alu_ref(w[14:12], w[30] && (w[14:12] == 3'd5), a, imm);
        op_lui:   res = {w[31:12], 12'b0};
        op_auipc: res = pc + {w[31:12], 12'b0};
        op_jal: begin
            res   = pc + 32'd4;
            npc   = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            taken = 1'b1;
        end
        op_jalr: begin
            res   = pc + 32'd4;
            npc   = (a + imm) & ~32'd1;  // low bit cleared
            taken = 1'b1;
        end
        op_branch: begin
            wr = 1'b0;
            case (w[14:12])
                3'd0: cond = a == b;
                3'd1: cond = a != b;
                3'd4: cond = $signed(a) < $signed(b);
                3'd5: cond = $signed(a) >= $signed(b);
                3'd6: cond = a < b;
                3'd7: cond = a >= b;
                default: cond = 1'b0;
            endcase
            if (cond) begin
                npc   = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                taken = 1'b1;
            end
        end
        default: begin
            if (w[14:12] == 3'd0) begin
                wr = 1'b0;
                if (w[31:20] == 12'h000) begin  // ecall
                    m_mepc   = pc;
                    m_mcause = 32'd11;
                    npc      = m_mtvec;
                end else begin
                    npc = m_mepc;               // mret
                end
            end else begin
                old = csr_read(w[31:20]);
                res = old;
                if (w[14:12] == 3'd1) begin
                    csr_write(w[31:20], a);
                end else if (w[19:15] != 5'd0) begin  // set/clear with x0 writes nothing
                    csr_write(w[31:20], (w[14:12] == 3'd2) ? (old | a) : (old & ~a));
                end
            end
        end
    endcase
    if (wr && (w[11:7] != 5'd0)) m_regs[w[11:7]] = res;
endtask

`endif

// ==== sim/tb_exu.sv ====
// ----------------------------------------------------------
// testbench for the RV32I execute unit with LFSR stimulus,
// reference model compare, latency and busy checks
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_exu;
    import exu_pkg::*;

    logic        clk;
    logic        rst;
    logic [31:0] op_i;
    logic        op_en_i;
    logic [31:0] pc_i;
    logic [4:0]  dbg_addr_i;
    logic        ex_end_o;
    logic [31:0] next_pc_o;
    logic        branch_taken_o;
    logic [31:0] dbg_data_o;

    logic [31:0] lfsr;
    logic [31:0] last_pc;
    int          errors;
    int          timeouts;

    `include "exu_ref_model.svh"

    exu_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .op_i           (op_i),
        .op_en_i        (op_en_i),
        .pc_i           (pc_i),
        .dbg_addr_i     (dbg_addr_i),
        .ex_end_o       (ex_end_o),
        .next_pc_o      (next_pc_o),
        .branch_taken_o (branch_taken_o),
        .dbg_data_o     (dbg_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(rand_bits(5));
    endfunction

    function automatic logic [31:0] rand_pc();
        return {30'(rand_bits(30)), 2'b00};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        instr_u u;
        u.r.funct7 = f7;
        u.r.rs2    = rs2;
        u.r.rs1    = rs1;
        u.r.funct3 = f3;
        u.r.rd     = rd;
        u.r.opcode = opc;
        return u;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        instr_u u;
        u.i.imm12  = imm;
        u.i.rs1    = rs1;
        u.i.funct3 = f3;
        u.i.rd     = rd;
        u.i.opcode = opc;
        return u;
    endfunction

    // upper 20 bits laid over the i view
    function automatic logic [31:0] enc_u(input logic [19:0] imm20, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return enc_i(imm20[19:8], imm20[7:3], imm20[2:0], rd, opc);
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return enc_r({off[12], off[10:5]}, rs2, rs1, f3, {off[4:1], off[11]}, op_branch);
    endfunction

    function automatic logic [11:0] csr_addr_of(input int k);
        case (k)
            0: return csr_mtvec;
            1: return csr_mepc;
            2: return csr_mcause;
            default: return csr_mstatus;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk);
        dbg_addr_i <= addr;
        @(negedge clk);
        data = dbg_data_o;
    endtask

    task automatic check_regs();
        logic [31:0] v;
        for (int k = 0; k < 32; k++) begin
            read_reg(5'(k), v);
            compare($sformatf("x%0d", k), v, m_regs[k]);
        end
    endtask

    // one request pulse and a wait for the ex_end_o toggle
    task automatic issue(input logic [31:0] w, input logic [31:0] pc, input logic extra);
        logic start;
        logic done;
        int   edges;
        start = ex_end_o;  // entered at a falling edge
        @(posedge clk);
        op_i    <= w;
        pc_i    <= pc;
        op_en_i <= 1'b1;
        @(posedge clk);    // request sampled here
        op_en_i <= 1'b0;
        edges = 0;
        done  = 1'b0;
        while (!done && (edges < 20)) begin
            @(posedge clk);
            edges++;
            if (extra && (edges == 1)) op_en_i <= 1'b1;  // stray pulse while busy
            if (edges == 2) op_en_i <= 1'b0;
            @(negedge clk);
            done = (ex_end_o != start);
        end
        if (!done) begin
            timeouts++;
            $display("timeout at %0t: ex_end_o never changed after the request", $time);
        end else begin
            compare("ex_end_o latency", edges, 32'd3);
        end
        if (extra) begin
            start = ex_end_o;
            repeat (4) @(negedge clk);
            compare("ex_end_o after busy pulse", {31'b0, ex_end_o}, {31'b0, start});
        end
    endtask

    task automatic run_instr(input logic [31:0] w, input logic extra);
        logic [31:0] exp_npc;
        logic        exp_taken;
        logic [31:0] v;
        last_pc = rand_pc();
        model_exec(w, last_pc, exp_npc, exp_taken);
        issue(w, last_pc, extra);
        compare("next_pc_o", next_pc_o, exp_npc);
        compare("branch_taken_o", {31'b0, branch_taken_o}, {31'b0, exp_taken});
        read_reg(w[11:7], v);
        compare($sformatf("x%0d", w[11:7]), v, m_regs[w[11:7]]);
        read_reg(5'd0, v);
        compare("x0", v, 32'h0);
    endtask

    initial begin
        logic [31:0] w;
        logic [31:0] v;
        logic [31:0] ecall_pc;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        op_i       = '0;
        op_en_i    = 1'b0;
        pc_i       = '0;
        dbg_addr_i = '0;
        rst        = 1'b1;
        lfsr       = 32'd30;
        last_pc    = '0;
        errors     = 0;
        timeouts   = 0;
        model_reset();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        compare("ex_end_o", {31'b0, ex_end_o}, 32'h0);
        compare("branch_taken_o", {31'b0, branch_taken_o}, 32'h0);
        compare("next_pc_o", next_pc_o, 32'h0);
        check_regs();

        // seed every register with lui then addi
        for (int r = 1; r < 32; r++) begin
            run_instr(enc_u(20'(rand_bits(20)), 5'(r), op_lui), 1'b0);
            run_instr(enc_i(12'(rand_bits(12)), 5'(r), 3'd0, 5'(r), op_imm), 1'b0);
        end

        for (int n = 0; n < 60; n++) begin
            rd  = rand_reg();
            rs1 = rand_reg();
            rs2 = rand_reg();
            f3  = 3'(rand_bits(3));
            alt = ((f3 == 3'd0) || (f3 == 3'd5)) && (rand_bits(1) != 0);
            if (rand_bits(1) != 0) begin
                w = enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd, op_reg);
            end else begin
                if ((f3 == 3'd1) || (f3 == 3'd5)) begin
                    imm = {1'b0, alt, 5'b0, 5'(rand_bits(5))};  // shamt form
                end else begin
                    imm = 12'(rand_bits(12));
                end
                w = enc_i(imm, rs1, f3, rd, op_imm);
            end
            run_instr(w, 1'b0);
        end

        // lui, auipc, jal, jalr
        for (int n = 0; n < 8; n++) begin
            rd  = rand_reg();
            rs1 = rand_reg();
            run_instr(enc_u(20'(rand_bits(20)), rd, op_lui), 1'b0);
            run_instr(enc_u(20'(rand_bits(20)), rd, op_auipc), 1'b0);
            joff = {20'(rand_bits(20)), 1'b0};
            run_instr(enc_u({joff[20], joff[10:1], joff[11], joff[19:12]}, rd, op_jal), 1'b0);
            run_instr(enc_i(12'(rand_bits(12)), rs1, 3'd0, rd, op_jalr), 1'b0);
            compare("jalr target bit 0", {31'b0, next_pc_o[0]}, 32'h0);
        end

        // equal pair in x5/x6 and sign-differing pair in x7/x8
        imm = 12'(rand_bits(12));
        run_instr(enc_i(imm, 5'd0, 3'd0, 5'd5, op_imm), 1'b0);
        run_instr(enc_i(imm, 5'd0, 3'd0, 5'd6, op_imm), 1'b0);
        run_instr(enc_u(20'h80000, 5'd7, op_lui), 1'b0);
        run_instr(enc_i(12'd5, 5'd0, 3'd0, 5'd8, op_imm), 1'b0);
        for (int n = 0; n < 36; n++) begin
            f3 = ((n % 6) < 2) ? 3'(n % 6) : 3'((n % 6) + 2);
            case (n / 6)
                0: begin
                    rs1 = 5'd5;
                    rs2 = 5'd6;
                end
                1: begin
                    rs1 = 5'd7;
                    rs2 = 5'd8;
                end
                2: begin
                    rs1 = 5'd8;
                    rs2 = 5'd7;
                end
                default: begin
                    rs1 = rand_reg();
                    rs2 = rand_reg();
                end
            endcase
            boff = {12'(rand_bits(12)), 1'b0};
            run_instr(enc_b(boff, rs2, rs1, f3), 1'b0);
        end

        // csrrw/csrrs/csrrc on each writable csr with rs1 = x0 in some
        for (int n = 0; n < 28; n++) begin
            rd  = rand_reg();
            rs1 = ((n >= 12) && ((n % 2) == 1)) ? 5'd0 : rand_reg();
            f3  = 3'(((n / 4) % 3) + 1);
            run_instr(enc_i(csr_addr_of(n % 4), rs1, f3, rd, op_system), 1'b0);
        end
        run_instr(enc_i(csr_mvendorid, 5'd0, f3_csrrs, 5'd9, op_system), 1'b0);
        read_reg(5'd9, v);
        compare("x9 mvendorid", v, 32'h7973_7978);
        run_instr(enc_i(csr_marchid, 5'd0, f3_csrrs, 5'd12, op_system), 1'b0);

        // trap entry and return
        run_instr(enc_i(funct12_ecall, 5'd0, f3_priv, 5'd0, op_system), 1'b0);
        ecall_pc = last_pc;
        run_instr(enc_i(csr_mepc, 5'd0, f3_csrrs, 5'd10, op_system), 1'b0);
        run_instr(enc_i(csr_mcause, 5'd0, f3_csrrs, 5'd11, op_system), 1'b0);
        read_reg(5'd10, v);
        compare("x10 mepc", v, ecall_pc);
        read_reg(5'd11, v);
        compare("x11 mcause", v, 32'd11);
        run_instr(enc_i(funct12_mret, 5'd0, f3_priv, 5'd0, op_system), 1'b0);

        // stray requests while busy
        for (int n = 0; n < 6; n++) begin
            rd  = rand_reg();
            rs1 = rand_reg();
            run_instr(enc_i(12'(rand_bits(12)), rs1, 3'd0, rd, op_imm), 1'b1);
        end
        check_regs();

        $display("summary: %0d value errors, %0d timeouts", errors, timeouts);
        if ((errors + timeouts) == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/exu_top.sv ====
// ----------------------------------------------------------
// exu_top: RV32I execute unit, joins control, ALU,
// register file and CSR file
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [exu_pkg::xlen-1:0]       op_i,
    input  logic                           op_en_i,
    input  logic [exu_pkg::xlen-1:0]       pc_i,
    input  logic [exu_pkg::reg_addr_w-1:0] dbg_addr_i,
    output logic                           ex_end_o,
    output logic [exu_pkg::xlen-1:0]       next_pc_o,
    output logic                           branch_taken_o,
    output logic [exu_pkg::xlen-1:0]       dbg_data_o
);
    import exu_pkg::*;

    logic [3:0]      alu_op;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_res;

    regfile_if rf_bus ();
    csr_if     csr_bus ();

    exu_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .op_i           (op_i),
        .op_en_i        (op_en_i),
        .pc_i           (pc_i),
        .rf             (rf_bus.ctrl),
        .csr            (csr_bus.ctrl),
        .alu_op_o       (alu_op),
        .alu_a_o        (alu_a),
        .alu_b_o        (alu_b),
        .alu_res_i      (alu_res),
        .ex_end_o       (ex_end_o),
        .next_pc_o      (next_pc_o),
        .branch_taken_o (branch_taken_o)
    );

    alu u_alu (
        .op_i  (alu_op),
        .a_i   (alu_a),
        .b_i   (alu_b),
        .res_o (alu_res)
    );

    regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .rf         (rf_bus.rf),
        .dbg_addr_i (dbg_addr_i),
        .dbg_data_o (dbg_data_o)
    );

    csr_file u_csr_file (
        .clk (clk),
        .rst (rst),
        .csr (csr_bus.csr)
    );

endmodule

`default_nettype wire

// ==== src/exu_ctrl.sv ====
// ----------------------------------------------------------
// exu_ctrl: four-state FSM, decode, operand selection,
// next-PC and register/CSR write-back control
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exu_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  exu_pkg::instr_u            op_i,
    input  logic                       op_en_i,
    input  logic [exu_pkg::xlen-1:0]   pc_i,
    regfile_if.ctrl                    rf,
    csr_if.ctrl                        csr,
    output logic [3:0]                 alu_op_o,
    output logic [exu_pkg::xlen-1:0]   alu_a_o,
    output logic [exu_pkg::xlen-1:0]   alu_b_o,
    input  logic [exu_pkg::xlen-1:0]   alu_res_i,
    output logic                       ex_end_o,
    output logic [exu_pkg::xlen-1:0]   next_pc_o,
    output logic                       branch_taken_o
);
    import exu_pkg::*;

    logic [1:0]      state;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] pc4;
    logic [xlen-1:0] br_tgt;
    logic [xlen-1:0] rd_val;
    logic [xlen-1:0] csr_new;
    logic            is_csr;
    logic            is_ecall;
    logic            is_mret;
    logic            writes_rd;
    logic            br_cond;

    assign opcode = op_i.r.opcode;
    assign funct3 = op_i.r.funct3;

    assign imm_i = {{20{op_i.i.imm12[11]}}, op_i.i.imm12};
    assign imm_b = {{20{op_i.r.funct7[6]}}, op_i.r.rd[0], op_i.r.funct7[5:0],
                    op_i.r.rd[4:1], 1'b0};
    assign imm_j = {{12{op_i[31]}}, op_i[19:12], op_i[20], op_i[30:21], 1'b0};
    assign imm_u = {op_i[31:12], 12'b0};

    assign pc4    = pc_i + 32'd4;
    assign br_tgt = pc_i + imm_b;

    assign is_csr   = (opcode == op_system) && (funct3 != f3_priv);
    assign is_ecall = (opcode == op_system) && (funct3 == f3_priv)
                      && (op_i.i.imm12 == funct12_ecall);
    assign is_mret  = (opcode == op_system) && (funct3 == f3_priv)
                      && (op_i.i.imm12 == funct12_mret);

    assign writes_rd = (opcode == op_reg) || (opcode == op_imm) || (opcode == op_lui)
                       || (opcode == op_auipc) || (opcode == op_jal)
                       || (opcode == op_jalr) || is_csr;

    // bne, bge and bgeu have funct3[0] set and invert the compare
    assign br_cond = alu_res_i[0] ^ funct3[0];

    assign csr.addr = op_i.i.imm12;
    assign csr.pc   = pc_i;

    // operand and operation select, jalr falls to rs1 + imm_i
    always_comb begin
        alu_op_o = alu_add;
        alu_a_o  = rf.rdata1;
        alu_b_o  = imm_i;
        case (opcode)
            op_reg: begin
                alu_op_o = {op_i.r.funct7[5], funct3};
                alu_b_o  = rf.rdata2;
            end
            op_imm:   alu_op_o = {(funct3 == 3'b101) && op_i.i.imm12[10], funct3};
            op_lui: begin
                alu_a_o = '0;
                alu_b_o = imm_u;
            end
            op_auipc: begin
                alu_a_o = pc_i;
                alu_b_o = imm_u;
            end
            op_jal: begin
                alu_a_o = pc_i;
                alu_b_o = imm_j;
            end
            op_branch: begin
                alu_b_o = rf.rdata2;
                case (funct3[2:1])
                    2'b00:   alu_op_o = alu_eq;
                    2'b10:   alu_op_o = alu_slt;
                    default: alu_op_o = alu_sltu;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        case (opcode)
            op_jal, op_jalr: rd_val = pc4;         // link
            op_system:       rd_val = csr.rdata;   // old CSR value
            default:         rd_val = alu_res_i;
        endcase
        case (funct3)
            f3_csrrw: csr_new = rf.rdata1;
            f3_csrrs: csr_new = csr.rdata | rf.rdata1;
            default:  csr_new = csr.rdata & ~rf.rdata1;
        endcase
    end

    // read addresses and write payload
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            rf.raddr1 <= op_i.r.rs1;
            rf.raddr2 <= op_i.r.rs2;
        end
        if (state == st_execute) begin
            rf.waddr  <= op_i.r.rd;
            rf.wdata  <= rd_val;
            csr.wdata <= csr_new;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= st_idle;
            ex_end_o       <= 1'b0;
            next_pc_o      <= '0;
            branch_taken_o <= 1'b0;
            rf.wen         <= 1'b0;
            csr.wen        <= 1'b0;
            csr.ecall      <= 1'b0;
            csr.mret       <= 1'b0;
        end else begin
            case (state)
                st_idle: if (op_en_i) state <= st_decode;
                st_decode: state <= st_execute;
                st_execute: begin
                    next_pc_o      <= pc4;
                    branch_taken_o <= 1'b0;
                    if ((opcode == op_jal) || (opcode == op_jalr)) begin
                        next_pc_o      <= {alu_res_i[xlen-1:1], 1'b0};
                        branch_taken_o <= 1'b1;
                    end else if ((opcode == op_branch) && br_cond) begin
                        next_pc_o      <= br_tgt;
                        branch_taken_o <= 1'b1;
                    end
                    rf.wen    <= writes_rd && (op_i.r.rd != '0);
                    csr.wen   <= is_csr && ((funct3 == f3_csrrw) || (op_i.r.rs1 != '0));
                    csr.ecall <= is_ecall;
                    csr.mret  <= is_mret;
                    state     <= st_writeback;
                end
                default: begin  // writeback
                    if (csr.ecall || csr.mret) next_pc_o <= csr.target;
                    rf.wen    <= 1'b0;
                    csr.wen   <= 1'b0;
                    csr.ecall <= 1'b0;
                    csr.mret  <= 1'b0;
                    ex_end_o  <= ~ex_end_o;
                    state     <= op_en_i ? st_decode : st_idle;  // back-to-back issue
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
// ----------------------------------------------------------
// alu: add/sub, shifts, logic ops and compares, shared by
// integer ops, jump targets and branch conditions
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [3:0]                 op_i,
    input  logic [exu_pkg::xlen-1:0]   a_i,
    input  logic [exu_pkg::xlen-1:0]   b_i,
    output logic [exu_pkg::xlen-1:0]   res_o
);
    import exu_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            alu_add:  res_o = a_i + b_i;
            alu_sub:  res_o = a_i - b_i;
            alu_sll:  res_o = a_i << shamt;
            alu_srl:  res_o = a_i >> shamt;
            alu_sra:  res_o = $signed(a_i) >>> shamt;
            alu_slt:  res_o = {{(xlen - 1){1'b0}}, lt_s};
            alu_sltu: res_o = {{(xlen - 1){1'b0}}, lt_u};
            alu_eq:   res_o = {{(xlen - 1){1'b0}}, a_i == b_i};
            alu_xor:  res_o = a_i ^ b_i;
            alu_or:   res_o = a_i | b_i;
            alu_and:  res_o = a_i & b_i;
            default:  res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/csr_file.sv ====
// ----------------------------------------------------------
// csr_file: machine CSRs with read mux, write port and
// ECALL trap state, drives the trap/return target
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input logic clk,
    input logic rst,
    csr_if.csr  csr
);
    import exu_pkg::*;

    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mstatus;

    always_comb begin
        case (csr.addr)
            csr_mstatus:   csr.rdata = mstatus;
            csr_mtvec:     csr.rdata = mtvec;
            csr_mepc:      csr.rdata = mepc;
            csr_mcause:    csr.rdata = mcause;
            csr_mvendorid: csr.rdata = mvendorid_val;
            csr_marchid:   csr.rdata = '0;
            default:       csr.rdata = '0;  // unimplemented
        endcase
    end

    assign csr.target = csr.ecall ? mtvec : mepc;  // trap entry or return

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtvec   <= mtvec_reset;
            mepc    <= '0;
            mcause  <= '0;
            mstatus <= '0;
        end else if (csr.ecall) begin
            mepc   <= csr.pc;
            mcause <= mcause_ecall;
        end else if (csr.wen) begin
            case (csr.addr)
                csr_mstatus: mstatus <= csr.wdata;
                csr_mtvec:   mtvec   <= csr.wdata;
                csr_mepc:    mepc    <= csr.wdata;
                csr_mcause:  mcause  <= csr.wdata;
                default:     ;  // read-only ids ignore writes
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
// ----------------------------------------------------------
// regfile: 32 x 32 integer registers, x0 stays zero,
// plus a combinational debug read port
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                           clk,
    input  logic                           rst,
    regfile_if.rf                          rf,
    input  logic [exu_pkg::reg_addr_w-1:0] dbg_addr_i,
    output logic [exu_pkg::xlen-1:0]       dbg_data_o
);
    import exu_pkg::*;

    logic [xlen-1:0] regs [0:(1 << reg_addr_w) - 1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < (1 << reg_addr_w); k++) begin
                regs[k] <= '0;
            end
        end else if (rf.wen && (rf.waddr != '0)) begin  // x0 writes dropped
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // x0 is never written, so it always reads back zero
    assign rf.rdata1  = regs[rf.raddr1];
    assign rf.rdata2  = regs[rf.raddr2];
    assign dbg_data_o = regs[dbg_addr_i];

endmodule

`default_nettype wire

// ==== src/csr_if.sv ====
// ----------------------------------------------------------
// CSR bus: access, trap entry/return and the trap target
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface csr_if;
    import exu_pkg::*;

    logic [csr_addr_w-1:0] addr;
    logic [xlen-1:0]       wdata;
    logic                  wen;
    logic                  ecall;   // pulse, saves pc and cause
    logic                  mret;    // pulse
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       rdata;
    logic [xlen-1:0]       target;  // mtvec or mepc

    modport ctrl (output addr, wdata, wen, ecall, mret, pc, input rdata, target);
    modport csr  (input addr, wdata, wen, ecall, mret, pc, output rdata, target);

endinterface

`default_nettype wire

// ==== src/regfile_if.sv ====
// ----------------------------------------------------------
// register file bus: two read ports and one write port
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface regfile_if;
    import exu_pkg::*;

    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
    logic                  wen;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;

    modport ctrl (output raddr1, raddr2, waddr, wdata, wen, input rdata1, rdata2);
    modport rf   (input raddr1, raddr2, waddr, wdata, wen, output rdata1, rdata2);

endinterface

`default_nettype wire

// ==== src/exu_pkg.sv ====
// ----------------------------------------------------------
// exu package: widths, RV32I encodings, ALU operation codes,
// machine CSR addresses and the shared instruction word
// ----------------------------------------------------------
`default_nettype none

package exu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 12;

    // major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_system = 7'b1110011;

    // system funct3 and funct12
    localparam logic [2:0]  f3_priv       = 3'b000;
    localparam logic [2:0]  f3_csrrw      = 3'b001;
    localparam logic [2:0]  f3_csrrs      = 3'b010;
    localparam logic [2:0]  f3_csrrc      = 3'b011;
    localparam logic [11:0] funct12_ecall = 12'h000;
    localparam logic [11:0] funct12_mret  = 12'h302;

    // ALU ops, low three bits line up with funct3 of the integer ops
    localparam logic [3:0] alu_add  = 4'b0000;
    localparam logic [3:0] alu_sll  = 4'b0001;
    localparam logic [3:0] alu_slt  = 4'b0010;
    localparam logic [3:0] alu_sltu = 4'b0011;
    localparam logic [3:0] alu_xor  = 4'b0100;
    localparam logic [3:0] alu_srl  = 4'b0101;
    localparam logic [3:0] alu_or   = 4'b0110;
    localparam logic [3:0] alu_and  = 4'b0111;
    localparam logic [3:0] alu_sub  = 4'b1000;
    localparam logic [3:0] alu_eq   = 4'b1001;
    localparam logic [3:0] alu_sra  = 4'b1101;

    localparam logic [csr_addr_w-1:0] csr_mstatus   = 12'h300;
    localparam logic [csr_addr_w-1:0] csr_mtvec     = 12'h305;
    localparam logic [csr_addr_w-1:0] csr_mepc      = 12'h341;
    localparam logic [csr_addr_w-1:0] csr_mcause    = 12'h342;
    localparam logic [csr_addr_w-1:0] csr_mvendorid = 12'hF11;
    localparam logic [csr_addr_w-1:0] csr_marchid   = 12'hF12;

    localparam logic [xlen-1:0] mtvec_reset   = 32'h8000_0000;
    localparam logic [xlen-1:0] mvendorid_val = 32'h7973_7978;  // "ysyx"
    localparam logic [xlen-1:0] mcause_ecall  = 32'd11;

    // control FSM states
    localparam logic [1:0] st_idle      = 2'd0;
    localparam logic [1:0] st_decode    = 2'd1;
    localparam logic [1:0] st_execute   = 2'd2;
    localparam logic [1:0] st_writeback = 2'd3;

    // one instruction word, seen as R-format or I-format
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i;
    } instr_u;

endpackage

`default_nettype wire
